/* Makefile */
TOP = tb_elem_unit

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* logic/elem_decode.sv */
/*
 * Element unit decode stage.
 * Registers an incoming element and turns its opcode into execute control.
 */
`timescale 1ns/1ps

module elem_decode import elem_pkg::*; (
        input  logic              clk_i,
        input  logic              async_rst_ni,

        input  logic              in_valid_i,
        output logic              in_ready_o,
        input  elem_ctrl_t        in_ctrl_i,
        input  elem_op_t          in_op_i,
        input  logic [WORD_W-1:0] in_op1_i,
        input  logic [WORD_W-1:0] in_op2_i,

        elem_pipe_if.sender       out_if
);

        logic         valid_q;
        exe_payload_t pay_q, pay_d;

        always_comb begin
                pay_d.ctrl     = in_ctrl_i;
                pay_d.op1      = in_op1_i;
                pay_d.op2      = in_op2_i;
                pay_d.cls      = CLS_ARITH;
                pay_d.sub      = 1'b0;
                pay_d.sgn      = 1'b0;
                pay_d.pick_max = 1'b0;
                unique case (in_op_i)
                        OP_MOVE: pay_d.cls = CLS_MOVE;
                        OP_ADD:  ;
                        OP_SUB:  pay_d.sub = 1'b1;
                        OP_MAXU: begin
                                pay_d.cls      = CLS_MINMAX;
                                pay_d.pick_max = 1'b1;
                        end
                        OP_MAX: begin
                                pay_d.cls      = CLS_MINMAX;
                                pay_d.sgn      = 1'b1;
                                pay_d.pick_max = 1'b1;
                        end
                        OP_MINU: pay_d.cls = CLS_MINMAX;
                        OP_MIN: begin
                                pay_d.cls = CLS_MINMAX;
                                pay_d.sgn = 1'b1;
                        end
                        default: ;   // Unused code acts as add.
                endcase
        end

        // One beat of storage.
        assign in_ready_o = ~valid_q | out_if.ready;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        valid_q <= 1'b0;
                end else if (in_ready_o) begin
                        valid_q <= in_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_valid_i & in_ready_o) begin
                        pay_q <= pay_d;
                end
        end

        assign out_if.valid   = valid_q;
        assign out_if.payload = pay_q;

endmodule

/* logic/elem_execute.sv */
/*
 * Element unit execute stage.
 * Move, add/sub and min/max at the element width, result registered.
 */
`timescale 1ns/1ps

module elem_execute import elem_pkg::*; (
        input  logic          clk_i,
        input  logic          async_rst_ni,

        elem_pipe_if.receiver in_if,
        elem_pipe_if.sender   out_if
);

        logic              valid_q;
        res_payload_t      res_q;
        exe_payload_t      in_pay;
        logic [WORD_W:0]   a_ext, b_ext;
        logic [WORD_W-1:0] sum, raw, res;
        logic              lt;

        // Extends one bit past the word so signed and unsigned compare alike.
        function automatic logic [WORD_W:0] ext(input logic [WORD_W-1:0] v,
                                                input eew_t eew, input logic sgn);
                unique case (eew)
                        EEW_8:   ext = {{(WORD_W-7){sgn & v[7]}}, v[7:0]};
                        EEW_16:  ext = {{(WORD_W-15){sgn & v[15]}}, v[15:0]};
                        default: ext = {sgn & v[WORD_W-1], v};
                endcase
        endfunction

        assign in_pay = in_if.payload;
        assign a_ext  = ext(in_pay.op1, in_pay.ctrl.eew, in_pay.sgn);
        assign b_ext  = ext(in_pay.op2, in_pay.ctrl.eew, in_pay.sgn);
        assign lt     = $signed(a_ext) < $signed(b_ext);
        assign sum    = in_pay.sub ? in_pay.op1 - in_pay.op2 : in_pay.op1 + in_pay.op2;

        always_comb begin
                unique case (in_pay.cls)
                        CLS_MOVE:  raw = in_pay.op1;
                        CLS_ARITH: raw = sum;
                        default:   raw = (in_pay.pick_max ^ lt) ? in_pay.op1 : in_pay.op2;
                endcase
        end

        // Wraps and clears the upper bytes.
        always_comb begin
                unique case (in_pay.ctrl.eew)
                        EEW_8:   res = {{(WORD_W-8){1'b0}}, raw[7:0]};
                        EEW_16:  res = {{(WORD_W-16){1'b0}}, raw[15:0]};
                        default: res = raw;
                endcase
        end

        assign in_if.ready = ~valid_q | out_if.ready;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        valid_q <= 1'b0;
                end else if (in_if.ready) begin
                        valid_q <= in_if.valid;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_if.valid & in_if.ready) begin
                        res_q.ctrl <= in_pay.ctrl;
                        res_q.res  <= res;
                end
        end

        assign out_if.valid   = valid_q;
        assign out_if.payload = res_q;

endmodule

/* logic/elem_pipe_if.sv */
/*
 * Valid/ready pipeline link between element unit stages.
 */
`timescale 1ns/1ps

interface elem_pipe_if #(
        parameter type payload_t = logic
);

        logic     valid;
        logic     ready;
        payload_t payload;

        // Payload holds from valid until the transfer.
        modport sender (
                output valid,
                output payload,
                input  ready
        );

        modport receiver (
                input  valid,
                input  payload,
                output ready
        );

endinterface

/* logic/elem_pkg.sv */
/*
 * Vector element unit shared definitions.
 * Widths, operation encodings and the stage payload structures.
 */
package elem_pkg;

        localparam int unsigned WORD_W     = 32;
        localparam int unsigned WORD_BYTES = WORD_W / 8;
        localparam int unsigned ID_W       = 3;
        localparam int unsigned VADDR_W    = 5;
        localparam int unsigned REG_WORDS  = 2;

        localparam int unsigned BYTE_OFS_W = $clog2(WORD_BYTES);            // Byte within a word.
        localparam int unsigned REG_OFS_W  = $clog2(REG_WORDS * WORD_BYTES); // Byte within a reg.
        localparam int unsigned GRP_CNT_W  = $clog2(8 * REG_WORDS * WORD_BYTES);

        typedef enum logic [1:0] {
                EEW_8,
                EEW_16,
                EEW_32
        } eew_t;

        typedef enum logic [1:0] {
                EMUL_1,
                EMUL_2,
                EMUL_4,
                EMUL_8
        } emul_t;

        typedef enum logic [2:0] {
                OP_MOVE,
                OP_ADD,
                OP_SUB,
                OP_MAXU,
                OP_MAX,
                OP_MINU,
                OP_MIN
        } elem_op_t;

        typedef enum logic [1:0] {
                CLS_MOVE,
                CLS_ARITH,
                CLS_MINMAX
        } op_class_t;

        typedef struct packed {
                logic [ID_W-1:0]    id;
                eew_t               eew;
                emul_t              emul;
                logic [VADDR_W-1:0] vaddr;
                logic               last;   // Final element of the instruction.
        } elem_ctrl_t;

        typedef struct packed {
                elem_ctrl_t         ctrl;
                op_class_t          cls;
                logic               sub;
                logic               sgn;
                logic               pick_max;
                logic [WORD_W-1:0]  op1;
                logic [WORD_W-1:0]  op2;
        } exe_payload_t;

        typedef struct packed {
                elem_ctrl_t         ctrl;
                logic [WORD_W-1:0]  res;    // Zero above the element width.
        } res_payload_t;

endpackage

/* logic/elem_result.sv */
/*
 * Element unit result stage.
 * Packs elements into words over a register group and pads after the last.
 */
`timescale 1ns/1ps

module elem_result import elem_pkg::*; (
        input  logic                  clk_i,
        input  logic                  async_rst_ni,

        elem_pipe_if.receiver         in_if,

        output logic                  out_valid_o,
        input  logic                  out_ready_i,
        output logic [ID_W-1:0]       out_id_o,
        output logic [VADDR_W-1:0]    out_vaddr_o,
        output logic [WORD_W-1:0]     out_data_o,
        output logic [WORD_BYTES-1:0] out_mask_o,
        output logic                  out_done_o
);

        logic [GRP_CNT_W-1:0]  cnt_q, cnt_d;
        logic [WORD_BYTES-1:0] mask_q, mask_d;
        logic [WORD_W-1:0]     word_q;
        logic                  flush_q, flush_d;
        logic [ID_W-1:0]       flush_id_q;
        emul_t                 flush_emul_q;
        logic [VADDR_W-1:0]    flush_vaddr_q;

        res_payload_t          in_pay;
        emul_t                 cur_emul;
        logic [GRP_CNT_W:0]    grp_bytes;
        logic [GRP_CNT_W-1:0]  grp_max, elem_bytes, end_byte;
        logic [BYTE_OFS_W-1:0] ofs;
        logic [WORD_BYTES-1:0] be_base, elem_be, merge_mask;
        logic [WORD_W-1:0]     elem_shift, merge_data, flush_data;
        logic                  word_full, grp_end, flush_end, accept;

        assign in_pay    = in_if.payload;
        assign cur_emul  = flush_q ? flush_emul_q : in_pay.ctrl.emul;
        assign grp_bytes = (GRP_CNT_W+1)'(REG_WORDS * WORD_BYTES) << cur_emul;
        assign grp_max   = GRP_CNT_W'(grp_bytes - 1'b1);   // Last byte of the group.

        always_comb begin
                unique case (in_pay.ctrl.eew)
                        EEW_8: begin
                                elem_bytes = GRP_CNT_W'(1);
                                be_base    = WORD_BYTES'(4'b0001);
                        end
                        EEW_16: begin
                                elem_bytes = GRP_CNT_W'(2);
                                be_base    = WORD_BYTES'(4'b0011);
                        end
                        default: begin
                                elem_bytes = GRP_CNT_W'(4);
                                be_base    = '1;
                        end
                endcase
        end

        assign ofs        = cnt_q[BYTE_OFS_W-1:0];
        assign end_byte   = cnt_q + elem_bytes - 1'b1;
        assign word_full  = end_byte[BYTE_OFS_W-1:0] == '1;
        assign grp_end    = end_byte == grp_max;
        assign flush_end  = cnt_q[GRP_CNT_W-1:BYTE_OFS_W] == grp_max[GRP_CNT_W-1:BYTE_OFS_W];
        assign elem_be    = be_base << ofs;
        assign elem_shift = in_pay.res << {ofs, 3'b000};
        assign merge_mask = mask_q | elem_be;

        // Bytes not yet written read as zero.
        always_comb begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                        flush_data[8*b +: 8] = mask_q[b] ? word_q[8*b +: 8] : 8'h00;
                        merge_data[8*b +: 8] = elem_be[b] ? elem_shift[8*b +: 8]
                                                          : flush_data[8*b +: 8];
                end
        end

        assign in_if.ready = ~flush_q & (~word_full | out_ready_i);
        assign accept      = in_if.valid & in_if.ready;

        assign out_valid_o = flush_q | (in_if.valid & word_full);
        assign out_id_o    = flush_q ? flush_id_q : in_pay.ctrl.id;
        assign out_vaddr_o = (flush_q ? flush_vaddr_q : in_pay.ctrl.vaddr)
                             + VADDR_W'(cnt_q[GRP_CNT_W-1:REG_OFS_W]);  // EMUL offset.
        assign out_data_o  = flush_q ? flush_data : merge_data;
        assign out_mask_o  = flush_q ? mask_q : merge_mask;
        assign out_done_o  = flush_q ? flush_end : (in_if.valid & in_pay.ctrl.last & grp_end);

        always_comb begin
                cnt_d   = cnt_q;
                mask_d  = mask_q;
                flush_d = flush_q;
                if (flush_q) begin
                        if (out_ready_i) begin
                                mask_d = '0;
                                if (flush_end) begin
                                        flush_d = 1'b0;
                                        cnt_d   = '0;
                                end else begin
                                        // Step to the next word boundary.
                                        cnt_d = {cnt_q[GRP_CNT_W-1:BYTE_OFS_W] + 1'b1,
                                                 {BYTE_OFS_W{1'b0}}};
                                end
                        end
                end else if (accept) begin
                        cnt_d   = grp_end ? '0 : end_byte + 1'b1;
                        mask_d  = word_full ? '0 : merge_mask;
                        flush_d = in_pay.ctrl.last & ~grp_end;
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        cnt_q   <= '0;
                        mask_q  <= '0;
                        flush_q <= 1'b0;
                end else begin
                        cnt_q   <= cnt_d;
                        mask_q  <= mask_d;
                        flush_q <= flush_d;
                end
        end

        always_ff @(posedge clk_i) begin
                if (accept) begin
                        word_q <= merge_data;
                end
                if (accept & in_pay.ctrl.last) begin
                        flush_id_q    <= in_pay.ctrl.id;
                        flush_emul_q  <= in_pay.ctrl.emul;
                        flush_vaddr_q <= in_pay.ctrl.vaddr;
                end
        end

endmodule

/* logic/elem_unit.sv */
/*
 * Vector element unit top level.
 * Decode, execute and result stages joined by valid/ready links.
 */
`timescale 1ns/1ps

module elem_unit import elem_pkg::*; (
        input  logic                  clk_i,
        input  logic                  async_rst_ni,

        input  logic                  in_valid_i,
        output logic                  in_ready_o,
        input  logic [ID_W-1:0]       in_id_i,
        input  elem_op_t              in_op_i,
        input  eew_t                  in_eew_i,
        input  emul_t                 in_emul_i,
        input  logic [VADDR_W-1:0]    in_vaddr_i,
        input  logic                  in_last_i,
        input  logic [WORD_W-1:0]     in_op1_i,
        input  logic [WORD_W-1:0]     in_op2_i,

        output logic                  out_valid_o,
        input  logic                  out_ready_i,
        output logic [ID_W-1:0]       out_id_o,
        output logic [VADDR_W-1:0]    out_vaddr_o,
        output logic [WORD_W-1:0]     out_data_o,
        output logic [WORD_BYTES-1:0] out_mask_o,
        output logic                  out_done_o
);

        elem_ctrl_t in_ctrl;

        elem_pipe_if #(.payload_t(exe_payload_t)) dec_exe ();
        elem_pipe_if #(.payload_t(res_payload_t)) exe_res ();

        assign in_ctrl = '{id: in_id_i, eew: in_eew_i, emul: in_emul_i,
                           vaddr: in_vaddr_i, last: in_last_i};

        elem_decode elem_decode_i (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .in_valid_i   ( in_valid_i   ),
                .in_ready_o   ( in_ready_o   ),
                .in_ctrl_i    ( in_ctrl      ),
                .in_op_i      ( in_op_i      ),
                .in_op1_i     ( in_op1_i     ),
                .in_op2_i     ( in_op2_i     ),
                .out_if       ( dec_exe      )
        );

        elem_execute elem_execute_i (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .in_if        ( dec_exe      ),
                .out_if       ( exe_res      )
        );

        elem_result elem_result_i (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .in_if        ( exe_res      ),
                .out_valid_o  ( out_valid_o  ),
                .out_ready_i  ( out_ready_i  ),
                .out_id_o     ( out_id_o     ),
                .out_vaddr_o  ( out_vaddr_o  ),
                .out_data_o   ( out_data_o   ),
                .out_mask_o   ( out_mask_o   ),
                .out_done_o   ( out_done_o   )
        );

endmodule

/* sim/elem_stimulus.txt */
# I op eew emul vaddr last op1 op2 id, all hex; op 0 move 1 add 2 sub 3 maxu 4 max 5 minu 6 min
# E id vaddr data mask done, all hex; eew 0/1/2 is 8/16/32 bits, emul 0..3 is 1/2/4/8 regs
I 1 0 0 4 0 aabbccff 00000002 1
I 2 0 0 4 0 00000005 00000007 1
I 1 0 0 4 0 00000080 00000080 1
I 2 0 0 4 0 00000010 00000001 1
I 1 0 0 4 0 0000007f 00000001 1
I 1 0 0 4 0 00000012 00000034 1
I 2 0 0 4 0 ffffff00 00000001 1
I 2 0 0 4 1 00000033 00000044 1
E 1 4 0f00fe01 f 0
E 1 4 efff4680 f 1
I 4 1 0 8 0 5555fff0 00000005 2
I 6 1 0 8 0 00008000 00007fff 2
I 3 1 0 8 0 0000fff0 00000005 2
I 5 1 0 8 1 00008000 00007fff 2
E 2 8 80000005 f 0
E 2 8 7ffffff0 f 1
I 0 2 1 10 0 deadbeef 00000000 3
I 0 2 1 10 0 01234567 00000000 3
I 0 2 1 10 0 89abcdef 00000000 3
I 0 2 1 10 1 cafef00d 00000000 3
E 3 10 deadbeef f 0
E 3 10 01234567 f 0
E 3 11 89abcdef f 0
E 3 11 cafef00d f 1
I 0 0 0 2 0 00000011 00000000 4
I 1 0 0 2 0 00000020 00000002 4
I 2 0 0 2 1 00000040 0000000d 4
E 4 2 00332211 7 0
E 4 2 00000000 0 1
I 1 1 1 18 0 0000ffff 00000001 5
I 2 1 1 18 0 00001000 00002000 5
I 1 1 1 18 1 00001234 00001111 5
E 5 18 f0000000 f 0
E 5 18 00002345 3 0
E 5 19 00000000 0 0
E 5 19 00000000 0 1

/* sim/tb_clock_gen.sv */
/*
 * Testbench clock and reset source.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD_NS  = 20,
        parameter int RST_CYCLES = 2
) (
        output logic clk_o,
        output logic rst_no
);

        initial begin
                clk_o = 1'b0;
                forever #(PERIOD_NS / 2) clk_o = ~clk_o;
        end

        // Released just after a rising edge.
        initial begin
                rst_no = 1'b0;
                repeat (RST_CYCLES) @(posedge clk_o);
                #2 rst_no = 1'b1;
        end

endmodule

/* sim/tb_elem_unit.sv */
/*
 * Testbench for the vector element unit.
 * Replays the stimulus file twice, the second time with random output stalls.
 */
`timescale 1ns/1ps

module tb_elem_unit import elem_pkg::*; ();

        localparam int CYCLES_PER_LINE = 40;

        typedef struct packed {
                logic [2:0]         op;
                logic [1:0]         eew;
                logic [1:0]         emul;
                logic [VADDR_W-1:0] vaddr;
                logic               last;
                logic [WORD_W-1:0]  op1;
                logic [WORD_W-1:0]  op2;
                logic [ID_W-1:0]    id;
        } elem_stim_t;

        typedef struct packed {
                logic [ID_W-1:0]       id;
                logic [VADDR_W-1:0]    vaddr;
                logic [WORD_W-1:0]     data;
                logic [WORD_BYTES-1:0] mask;
                logic                  done;
        } exp_word_t;

        logic                  clk_i, rst_n;
        logic                  in_valid_i, in_ready_o, in_last_i;
        logic [ID_W-1:0]       in_id_i;
        elem_op_t              in_op_i;
        eew_t                  in_eew_i;
        emul_t                 in_emul_i;
        logic [VADDR_W-1:0]    in_vaddr_i;
        logic [WORD_W-1:0]     in_op1_i, in_op2_i;
        logic                  out_valid_o, out_ready_i, out_done_o;
        logic [ID_W-1:0]       out_id_o;
        logic [VADDR_W-1:0]    out_vaddr_o;
        logic [WORD_W-1:0]     out_data_o;
        logic [WORD_BYTES-1:0] out_mask_o;

        elem_stim_t stim_q[$];
        exp_word_t  exp_q[$];
        int         errors = 0;
        int         words_seen = 0;
        int         instr_seen = 0;
        int         instr_words = 0;
        int         instr_err_base = 0;
        bit         loaded;
        bit         stall_en;
        integer     seed = 32'h287a;

        tb_clock_gen clock_gen_i (
                .clk_o  ( clk_i ),
                .rst_no ( rst_n )
        );

        elem_unit elem_unit_i (
                .clk_i        ( clk_i       ),
                .async_rst_ni ( rst_n       ),
                .in_valid_i   ( in_valid_i  ),
                .in_ready_o   ( in_ready_o  ),
                .in_id_i      ( in_id_i     ),
                .in_op_i      ( in_op_i     ),
                .in_eew_i     ( in_eew_i    ),
                .in_emul_i    ( in_emul_i   ),
                .in_vaddr_i   ( in_vaddr_i  ),
                .in_last_i    ( in_last_i   ),
                .in_op1_i     ( in_op1_i    ),
                .in_op2_i     ( in_op2_i    ),
                .out_valid_o  ( out_valid_o ),
                .out_ready_i  ( out_ready_i ),
                .out_id_o     ( out_id_o    ),
                .out_vaddr_o  ( out_vaddr_o ),
                .out_data_o   ( out_data_o  ),
                .out_mask_o   ( out_mask_o  ),
                .out_done_o   ( out_done_o  )
        );

        task automatic load_stimulus();
                integer           fd, code;
                logic [63:0]      tag;
                logic [8*128-1:0] rest;
                logic [31:0]      f [8];
                elem_stim_t       s;
                exp_word_t        e;
                fd = $fopen("sim/elem_stimulus.txt", "r");
                if (fd != 0) begin
                        while (!$feof(fd)) begin
                                code = $fscanf(fd, "%s", tag);
                                if (code != 1) break;
                                if (tag == "I") begin
                                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f[0], f[1],
                                                       f[2], f[3], f[4], f[5], f[6], f[7]);
                                        s.op    = f[0][2:0];
                                        s.eew   = f[1][1:0];
                                        s.emul  = f[2][1:0];
                                        s.vaddr = f[3][VADDR_W-1:0];
                                        s.last  = f[4][0];
                                        s.op1   = f[5];
                                        s.op2   = f[6];
                                        s.id    = f[7][ID_W-1:0];
                                        stim_q.push_back(s);
                                end else if (tag == "E") begin
                                        code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2],
                                                       f[3], f[4]);
                                        e.id    = f[0][ID_W-1:0];
                                        e.vaddr = f[1][VADDR_W-1:0];
                                        e.data  = f[2];
                                        e.mask  = f[3][WORD_BYTES-1:0];
                                        e.done  = f[4][0];
                                        exp_q.push_back(e);
                                end else begin
                                        code = $fgets(rest, fd);   // Comment line.
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic send_element(input elem_stim_t s);
                in_valid_i = 1'b1;
                in_id_i    = s.id;
                in_op_i    = elem_op_t'(s.op);
                in_eew_i   = eew_t'(s.eew);
                in_emul_i  = emul_t'(s.emul);
                in_vaddr_i = s.vaddr;
                in_last_i  = s.last;
                in_op1_i   = s.op1;
                in_op2_i   = s.op2;
                @(negedge clk_i);
                while (!in_ready_o) begin
                        @(negedge clk_i);
                end
                @(posedge clk_i);   // Beat taken here.
                #2;
                in_valid_i = 1'b0;
        endtask

        task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                                   input string what);
                if (got !== exp) begin
                        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
                        errors++;
                end
        endtask

        task automatic check_word();
                exp_word_t e;
                string     where;
                if (words_seen >= 2 * exp_q.size()) begin
                        $display("Extra output word %h at %0t, no more words were expected",
                                 out_data_o, $time);
                        errors++;
                end else begin
                        e     = exp_q[words_seen % exp_q.size()];
                        where = $sformatf("id %0d word %0d", e.id, instr_words);
                        check_value(32'(out_id_o), 32'(e.id), {where, " id"});
                        check_value(32'(out_vaddr_o), 32'(e.vaddr), {where, " vaddr"});
                        check_value(out_data_o, e.data, {where, " data"});
                        check_value(32'(out_mask_o), 32'(e.mask), {where, " mask"});
                        check_value(32'(out_done_o), 32'(e.done), {where, " done"});
                        instr_words++;
                        if (e.done) begin
                                $display("pass %0d id %0d: %0d words, %s",
                                         words_seen / exp_q.size() + 1, e.id, instr_words,
                                         (errors == instr_err_base) ? "ok" : "mismatch");
                                instr_seen++;
                                instr_words    = 0;
                                instr_err_base = errors;
                        end
                end
                words_seen++;
        endtask

        // Sampled mid-cycle, a word moves when valid and ready.
        always @(negedge clk_i) begin
                if (rst_n && out_valid_o && out_ready_i) begin
                        check_word();
                end
        end

        initial begin : ready_gen
                out_ready_i = 1'b0;
                forever begin
                        @(posedge clk_i);
                        #2;
                        if (stall_en) begin
                                out_ready_i = ($random(seed) & 3) != 0;   // Low one time in four.
                        end else begin
                                out_ready_i = 1'b1;
                        end
                end
        end

        initial begin : watchdog
                int limit;
                wait (loaded);
                limit = 2 * CYCLES_PER_LINE * (stim_q.size() + exp_q.size());
                repeat (limit) @(posedge clk_i);
                $display("Timeout after %0d cycles, only %0d of %0d output words arrived",
                         limit, words_seen, 2 * exp_q.size());
                $display("test failed");
                $finish;
        end

        initial begin : main
                in_valid_i = 1'b0;
                in_id_i    = '0;
                in_op_i    = OP_MOVE;
                in_eew_i   = EEW_8;
                in_emul_i  = EMUL_1;
                in_vaddr_i = '0;
                in_last_i  = 1'b0;
                in_op1_i   = '0;
                in_op2_i   = '0;
                load_stimulus();
                loaded = 1'b1;
                if (stim_q.size() == 0 || exp_q.size() == 0) begin
                        $display("Stimulus file sim/elem_stimulus.txt is missing or empty");
                        $display("test failed");
                        $finish;
                end else begin
                        wait (rst_n);
                        @(posedge clk_i);
                        #2;
                        for (int pass = 0; pass < 2; pass++) begin
                                stall_en = (pass == 1);
                                foreach (stim_q[i]) begin
                                        send_element(stim_q[i]);
                                end
                        end
                        wait (words_seen >= 2 * exp_q.size());
                        repeat (4) @(posedge clk_i);   // Catch stray words.
                        $display("%0d instructions, %0d words checked, %0d errors",
                                 instr_seen, words_seen, errors);
                        if (errors == 0) begin
                                $display("test passed");
                        end else begin
                                $display("test failed");
                        end
                        $finish;
                end
        end

endmodule

/* tb.f */
logic/elem_pkg.sv
logic/elem_pipe_if.sv
logic/elem_decode.sv
logic/elem_execute.sv
logic/elem_result.sv
logic/elem_unit.sv
sim/tb_clock_gen.sv
sim/tb_elem_unit.sv
